// File: logic/fetch_macros.svh
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// Fetch buffer
`define FB_DEPTH 8

// Direct-mapped I-cache geometry with 8-byte lines
`define CACHE_LINES 32
`define IDX_W 5
`define TAG_W 8

`define MEM_TAG_W 4

`define RESET_PC 64'h0

`endif

// File: logic/fetch_pkg.sv
`default_nettype none

`include "fetch_macros.svh"

package fetch_pkg;

  typedef logic [63:0] addr_t;
  typedef logic [31:0] inst_t;
  typedef logic [63:0] line_t;                 // Two instructions per line

  typedef logic [`IDX_W-1:0]     cache_idx_t;  // addr[7:3]
  typedef logic [`TAG_W-1:0]     cache_tag_t;  // addr[15:8]
  typedef logic [`MEM_TAG_W-1:0] mem_tag_t;    // Zero means no tag

  typedef logic [$clog2(`FB_DEPTH)-1:0]   fb_ptr_t;
  typedef logic [$clog2(`FB_DEPTH+1)-1:0] fb_cnt_t;

  typedef enum logic [1:0] {
    BUS_NONE = 2'h0,
    BUS_LOAD = 2'h1
  } bus_cmd_e;

  typedef enum logic [1:0] {
    IDLE,
    REQUEST,
    WAIT_DATA
  } miss_state_e;

  typedef struct packed {
    bus_cmd_e command;
    addr_t    addr;
  } mem_req_t;

  typedef struct packed {
    mem_tag_t response;  // Nonzero when the request is accepted
    line_t    data;
    mem_tag_t tag;       // Tag of the data beat
  } mem_rsp_t;

  typedef struct packed {
    addr_t pc;
    inst_t inst;
  } fetch_entry_t;

  typedef struct packed {
    logic  valid;
    addr_t pc;
  } redirect_t;

endpackage

`default_nettype wire

// File: logic/icache_mem.sv
`default_nettype none

`include "fetch_macros.svh"

module icache_mem (
  input  logic                  clock,
  input  logic                  rst,
  input  fetch_pkg::cache_idx_t rd_idx,
  input  fetch_pkg::cache_tag_t rd_tag,
  input  logic                  wr_en,
  input  fetch_pkg::cache_idx_t wr_idx,
  input  fetch_pkg::cache_tag_t wr_tag,
  input  fetch_pkg::line_t      wr_line,
  output fetch_pkg::line_t      rd_line,
  output logic                  rd_hit
);
  import fetch_pkg::*;

  line_t                  lines [`CACHE_LINES];
  cache_tag_t             tags  [`CACHE_LINES];
  logic [`CACHE_LINES-1:0] valid;

  always_ff @(posedge clock) begin
    if (rst) begin
      valid <= '0;
    end else if (wr_en) begin
      valid[wr_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (wr_en) begin
      lines[wr_idx] <= wr_line;
      tags[wr_idx]  <= wr_tag;
    end
  end

  // Combinational lookup
  assign rd_line = lines[rd_idx];
  assign rd_hit  = valid[rd_idx] && (tags[rd_idx] == rd_tag);

endmodule

`default_nettype wire

// File: logic/icache_ctrl.sv
`default_nettype none

module icache_ctrl (
  input  logic                  clock,
  input  logic                  rst,
  input  fetch_pkg::cache_idx_t rd_idx,
  input  fetch_pkg::cache_tag_t rd_tag,
  input  logic                  rd_hit,
  input  fetch_pkg::mem_rsp_t   mem_rsp,
  output fetch_pkg::mem_req_t   mem_req,
  output logic                  wr_en,
  output fetch_pkg::cache_idx_t wr_idx,
  output fetch_pkg::cache_tag_t wr_tag,
  output fetch_pkg::line_t      wr_line
);
  import fetch_pkg::*;

  miss_state_e state;
  miss_state_e next_state;
  cache_idx_t  miss_idx;
  cache_tag_t  miss_tag;
  mem_tag_t    rsp_tag;   // Tag granted by memory
  logic        accepted;
  logic        fill;

  assign accepted = (state == REQUEST) && (mem_rsp.response != '0);
  assign fill     = (state == WAIT_DATA) && (mem_rsp.tag == rsp_tag);

  always_comb begin
    next_state = state;
    case (state)
      IDLE:      if (!rd_hit) next_state = REQUEST;
      REQUEST:   if (accepted) next_state = WAIT_DATA;
      WAIT_DATA: if (fill) next_state = IDLE;
      default:   next_state = IDLE;
    endcase
  end

  always_ff @(posedge clock) begin
    if (rst) begin
      state   <= IDLE;
      rsp_tag <= '0;
    end else begin
      state <= next_state;
      if (accepted) rsp_tag <= mem_rsp.response;
    end
  end

  // Missing line held until the fill
  always_ff @(posedge clock) begin
    if (state == IDLE && !rd_hit) begin
      miss_idx <= rd_idx;
      miss_tag <= rd_tag;
    end
  end

  always_comb begin
    mem_req.command = BUS_NONE;
    mem_req.addr    = '0;
    if (state == REQUEST) begin
      mem_req.command = BUS_LOAD;
      mem_req.addr    = addr_t'({miss_tag, miss_idx, 3'b000});  // Line aligned
    end
  end

  assign wr_en   = fill;
  assign wr_idx  = miss_idx;
  assign wr_tag  = miss_tag;
  assign wr_line = mem_rsp.data;

endmodule

`default_nettype wire

// File: logic/fetch_stage.sv
`default_nettype none

`include "fetch_macros.svh"

module fetch_stage (
  input  logic                    clock,
  input  logic                    rst,
  input  fetch_pkg::redirect_t    redirect,
  input  fetch_pkg::line_t        rd_line,
  input  logic                    rd_hit,
  output fetch_pkg::cache_idx_t   rd_idx,
  output fetch_pkg::cache_tag_t   rd_tag,
  output fetch_pkg::fetch_entry_t push_entry,
  output logic                    push_valid,
  input  logic                    push_ready
);
  import fetch_pkg::*;

  addr_t pc;
  inst_t inst;

  assign rd_idx = pc[7:3];
  assign rd_tag = pc[15:8];

  // Word select within the line
  assign inst = pc[2] ? rd_line[63:32] : rd_line[31:0];

  assign push_valid      = rd_hit;
  assign push_entry.pc   = pc;
  assign push_entry.inst = inst;

  always_ff @(posedge clock) begin
    if (rst) begin
      pc <= addr_t'(`RESET_PC);
    end else if (redirect.valid) begin
      pc <= redirect.pc;
    end else if (push_valid && push_ready) begin
      pc <= pc + addr_t'(4);
    end
  end

endmodule

`default_nettype wire

// File: logic/fetch_queue_ptrs.sv
`default_nettype none

`include "fetch_macros.svh"

module fetch_queue_ptrs (
  input  logic               clock,
  input  logic               rst,
  input  logic               flush,
  input  logic               push,
  input  logic               pop,
  output fetch_pkg::fb_ptr_t head,
  output fetch_pkg::fb_ptr_t tail,
  output logic               full,
  output logic               empty
);
  import fetch_pkg::*;

  fb_cnt_t count;

  function automatic fb_ptr_t ptr_inc(input fb_ptr_t p);
    ptr_inc = (p == fb_ptr_t'(`FB_DEPTH - 1)) ? '0 : p + fb_ptr_t'(1);
  endfunction

  always_ff @(posedge clock) begin
    if (rst || flush) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (push) tail <= ptr_inc(tail);
      if (pop) head <= ptr_inc(head);
      case ({push, pop})
        2'b10:   count <= count + fb_cnt_t'(1);
        2'b01:   count <= count - fb_cnt_t'(1);
        default: count <= count;  // Both or neither
      endcase
    end
  end

  assign full  = (count == fb_cnt_t'(`FB_DEPTH));
  assign empty = (count == '0);

endmodule

`default_nettype wire

// File: logic/fetch_buffer.sv
`default_nettype none

`include "fetch_macros.svh"

module fetch_buffer (
  input  logic                    clock,
  input  logic                    rst,
  input  fetch_pkg::redirect_t    redirect,
  input  fetch_pkg::fetch_entry_t push_entry,
  input  logic                    push_valid,
  output logic                    push_ready,
  output fetch_pkg::fetch_entry_t out_entry,
  output logic                    out_valid,
  input  logic                    out_ready
);
  import fetch_pkg::*;

  fetch_entry_t entries [`FB_DEPTH];
  fb_ptr_t      head;
  fb_ptr_t      tail;
  logic         full;
  logic         empty;
  logic         push;
  logic         pop;

  // Push dropped in the flush cycle
  assign push = push_valid && !full && !redirect.valid;
  assign pop  = out_valid && out_ready;

  fetch_queue_ptrs ptrs (
    .clock (clock),
    .rst   (rst),
    .flush (redirect.valid),
    .push  (push),
    .pop   (pop),
    .head  (head),
    .tail  (tail),
    .full  (full),
    .empty (empty)
  );

  always_ff @(posedge clock) begin
    if (push) begin
      entries[tail] <= push_entry;
    end
  end

  assign push_ready = !full;
  assign out_valid  = !empty;
  assign out_entry  = entries[head];

endmodule

`default_nettype wire

// File: logic/fetch_top.sv
`default_nettype none

module fetch_top (
  input  logic                    clock,
  input  logic                    rst,
  input  fetch_pkg::mem_rsp_t     mem_rsp,
  output fetch_pkg::mem_req_t     mem_req,
  input  fetch_pkg::redirect_t    redirect,
  output fetch_pkg::fetch_entry_t out_entry,
  output logic                    out_valid,
  input  logic                    out_ready
);
  import fetch_pkg::*;

  cache_idx_t   rd_idx;
  cache_tag_t   rd_tag;
  line_t        rd_line;
  logic         rd_hit;
  logic         wr_en;
  cache_idx_t   wr_idx;
  cache_tag_t   wr_tag;
  line_t        wr_line;
  fetch_entry_t push_entry;
  logic         push_valid;
  logic         push_ready;

  icache_mem cache_mem (
    .clock   (clock),
    .rst     (rst),
    .rd_idx  (rd_idx),
    .rd_tag  (rd_tag),
    .wr_en   (wr_en),
    .wr_idx  (wr_idx),
    .wr_tag  (wr_tag),
    .wr_line (wr_line),
    .rd_line (rd_line),
    .rd_hit  (rd_hit)
  );

  // Miss handling owns the memory port
  icache_ctrl cache_ctrl (
    .clock   (clock),
    .rst     (rst),
    .rd_idx  (rd_idx),
    .rd_tag  (rd_tag),
    .rd_hit  (rd_hit),
    .mem_rsp (mem_rsp),
    .mem_req (mem_req),
    .wr_en   (wr_en),
    .wr_idx  (wr_idx),
    .wr_tag  (wr_tag),
    .wr_line (wr_line)
  );

  fetch_stage fetch (
    .clock      (clock),
    .rst        (rst),
    .redirect   (redirect),
    .rd_line    (rd_line),
    .rd_hit     (rd_hit),
    .rd_idx     (rd_idx),
    .rd_tag     (rd_tag),
    .push_entry (push_entry),
    .push_valid (push_valid),
    .push_ready (push_ready)
  );

  fetch_buffer fbuf (
    .clock      (clock),
    .rst        (rst),
    .redirect   (redirect),
    .push_entry (push_entry),
    .push_valid (push_valid),
    .push_ready (push_ready),
    .out_entry  (out_entry),
    .out_valid  (out_valid),
    .out_ready  (out_ready)
  );

endmodule

`default_nettype wire

// File: bench/fetch_props.sv
`default_nettype none

module fetch_props (
  input logic                    clock,
  input logic                    rst,
  input fetch_pkg::mem_req_t     mem_req,
  input fetch_pkg::redirect_t    redirect,
  input fetch_pkg::fetch_entry_t out_entry,
  input logic                    out_valid,
  input logic                    out_ready
);
  timeunit 1ns;
  timeprecision 100ps;
  import fetch_pkg::*;

  // Miss FSM back in IDLE one cycle into reset
  bus_idle_after_reset: assert property (
    @(posedge clock) rst |=> mem_req.command == BUS_NONE
  ) else $error("memory bus command is not BUS_NONE after reset");

  // Stalled head entry holds unless a flush empties the buffer
  out_entry_held: assert property (
    @(posedge clock) disable iff (rst)
    out_valid && !out_ready && !redirect.valid |=> out_valid && $stable(out_entry)
  ) else $error("fetch buffer output changed while stalled");

endmodule

`default_nettype wire

// File: bench/fetch_tb.sv
`default_nettype none

`include "fetch_macros.svh"

module fetch_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import fetch_pkg::*;

  typedef struct packed {
    logic        do_redirect;
    addr_t       pc;
    logic [7:0]  count;      // Instructions to take
    logic [15:0] ready_pat;  // out_ready bit per cycle
    logic        reject;     // Refuse the first request
    logic        no_loads;
    logic        first_load; // First load must be the redirect line
    logic        settle;     // Wait for an idle bus afterwards
  } stim_row_t;

  localparam int    num_rows     = 7;
  localparam int    miss_worst   = 16;  // Worst miss latency in cycles
  localparam int    quiet_cycles = `FB_DEPTH + 4;
  localparam inst_t inst_key     = 32'h5a3c_96e1;

  stim_row_t rows [num_rows] = '{
    '{1'b0, 64'h0000, 8'd12, 16'hffff, 1'b0, 1'b0, 1'b1, 1'b1},  // From reset
    '{1'b1, 64'h0000, 8'd8,  16'hffff, 1'b0, 1'b1, 1'b0, 1'b1},  // Cached refetch
    '{1'b1, 64'h0100, 8'd6,  16'hffff, 1'b0, 1'b0, 1'b1, 1'b1},  // Same index, new tag
    '{1'b1, 64'h0400, 8'd20, 16'hb26d, 1'b0, 1'b0, 1'b1, 1'b1},
    '{1'b1, 64'h0800, 8'd6,  16'hffff, 1'b1, 1'b0, 1'b1, 1'b1},  // Rejected request
    '{1'b1, 64'h1004, 8'd10, 16'hc3a5, 1'b0, 1'b0, 1'b1, 1'b0},
    '{1'b1, 64'h00c4, 8'd8,  16'h7777, 1'b0, 1'b0, 1'b0, 1'b1}   // Redirect under traffic
  };

  logic         clock;
  logic         rst;
  mem_rsp_t     mem_rsp;
  mem_req_t     mem_req;
  redirect_t    redirect;
  fetch_entry_t out_entry;
  logic         out_valid;
  logic         out_ready;

  // Memory model state
  mem_tag_t next_tag = 4'd1;
  logic     beat_pending = 1'b0;
  mem_tag_t beat_tag;
  addr_t    beat_addr;
  int       beat_delay;
  int       hold = 0;
  logic     reject_armed = 1'b0;
  logic     retry_check = 1'b0;
  addr_t    rejected_addr;
  logic     bus_quiet = 1'b0;
  int       load_count;
  addr_t    first_load;

  addr_t    expected_pc;
  int       taken;
  int       cycle_count = 0;
  int       cycle_limit;

  fetch_top uut (
    .clock     (clock),
    .rst       (rst),
    .mem_rsp   (mem_rsp),
    .mem_req   (mem_req),
    .redirect  (redirect),
    .out_entry (out_entry),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  bind fetch_top fetch_props props (
    .clock     (clock),
    .rst       (rst),
    .mem_req   (mem_req),
    .redirect  (redirect),
    .out_entry (out_entry),
    .out_valid (out_valid),
    .out_ready (out_ready)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  // Word address folded to 32 bits
  function automatic inst_t inst_at(input addr_t a);
    addr_t w;
    w = a >> 2;
    inst_at = w[31:0] ^ {2'b00, w[61:32]} ^ inst_key;
  endfunction

  function automatic line_t line_at(input addr_t a);
    addr_t base;
    base = {a[63:3], 3'b000};
    line_at = {inst_at(base + 64'd4), inst_at(base)};
  endfunction

  function automatic int run_budget();
    int total;
    total = 8;
    for (int r = 0; r < num_rows; r++) begin
      total += (int'(rows[r].count) + `FB_DEPTH) * miss_worst + quiet_cycles;
    end
    return total;
  endfunction

  task automatic abort_run();
    $display("*** FAILED ***");
    $fatal(1, "run stopped");
  endtask

  task automatic check_entry(input fetch_entry_t got, input fetch_entry_t exp,
                             input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s: got pc %h inst %h, expected pc %h inst %h",
               $time, what, got.pc, got.inst, exp.pc, exp.inst);
      abort_run();
    end
  endtask

  task automatic check_addr(input addr_t got, input addr_t exp, input string what);
    if (got !== exp) begin
      $display("[ERROR] %0t: %s: got %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      $display("[ERROR] %0t: %s: got %0d, expected %0d", $time, what, got, exp);
      abort_run();
    end
  endtask

  // Sees the bus as it was just before the edge
  task automatic serve_memory();
    mem_rsp_t rsp_next;
    rsp_next = '0;
    bus_quiet = 1'b0;
    if (!rst) begin
      if (beat_pending) begin
        if (beat_delay == 0) begin
          rsp_next.tag  = beat_tag;
          rsp_next.data = line_at(beat_addr);
          beat_pending  = 1'b0;
        end else begin
          beat_delay--;
        end
      end
      if (mem_req.command == BUS_LOAD) begin
        load_count++;  // Cycles with a load on the bus
        if (load_count == 1) first_load = mem_req.addr;
        if (mem_rsp.response != '0) begin
          beat_pending = 1'b1;  // Accepted at this edge
          beat_tag     = mem_rsp.response;
          beat_addr    = mem_req.addr;
          beat_delay   = int'($urandom % 6);
          if (retry_check) begin
            check_addr(mem_req.addr, rejected_addr, "address of retried load");
            retry_check = 1'b0;
          end
        end else if (reject_armed) begin
          reject_armed  = 1'b0;
          retry_check   = 1'b1;
          rejected_addr = mem_req.addr;
          hold          = 3;
        end else if (hold > 0) begin
          hold--;
        end else begin
          rsp_next.response = next_tag;
          next_tag = (next_tag == 4'd15) ? 4'd1 : next_tag + 4'd1;
        end
      end
      bus_quiet = (mem_req.command == BUS_NONE) && !beat_pending && (rsp_next == '0);
    end
    mem_rsp <= rsp_next;
  endtask

  task automatic collect_output();
    fetch_entry_t exp;
    if (!rst && out_valid && out_ready) begin
      exp.pc   = expected_pc;
      exp.inst = inst_at(expected_pc);
      check_entry(out_entry, exp, "delivered entry");
      expected_pc = expected_pc + 64'd4;
      taken++;
    end
  endtask

  task automatic step_cycle();
    @(posedge clock);
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      abort_run();
    end
    serve_memory();
    collect_output();
  endtask

  task automatic apply_row(input stim_row_t row);
    redirect_t rd;
    int        i;
    int        quiet;
    load_count   = 0;
    first_load   = '1;
    reject_armed = row.reject;
    expected_pc  = addr_t'(`RESET_PC);
    if (row.do_redirect) begin
      rd.valid = 1'b1;
      rd.pc    = row.pc;
      out_ready <= 1'b0;  // Nothing taken in the flush cycle
      redirect  <= rd;
      step_cycle();
      redirect <= '0;
      expected_pc = row.pc;
    end
    taken = 0;
    i = 0;
    while (taken < int'(row.count)) begin
      out_ready <= row.ready_pat[i[3:0]];
      i++;
      step_cycle();
    end
    out_ready <= 1'b0;
    if (row.no_loads) begin
      check_count(load_count, 0, "bus loads for cached lines");
    end
    if (row.first_load) begin
      check_addr(first_load, {row.pc[63:3], 3'b000}, "first load after redirect");
    end
    if (row.settle) begin
      quiet = 0;
      while (quiet < quiet_cycles) begin
        step_cycle();
        quiet = bus_quiet ? quiet + 1 : 0;
      end
    end
  endtask

  initial begin
    void'($urandom(13077));
    rst       <= 1'b1;
    mem_rsp   <= '0;
    redirect  <= '0;
    out_ready <= 1'b0;
    cycle_limit = run_budget();
    repeat (8) step_cycle();
    rst <= 1'b0;
    for (int r = 0; r < num_rows; r++) begin
      apply_row(rows[r]);
    end
    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+logic
logic/fetch_pkg.sv
logic/icache_mem.sv
logic/icache_ctrl.sv
logic/fetch_stage.sv
logic/fetch_queue_ptrs.sv
logic/fetch_buffer.sv
logic/fetch_top.sv
bench/fetch_props.sv
bench/fetch_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the fetch front-end testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
  -f sources.f --top-module fetch_tb -o fetch_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/fetch_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
  exit 1
fi
exit 0
